// ==== Bender.yml ====
package:
  name: kitchen

export_include_dirs:
  - include

sources:
  - files:
      - source/kitchen_pkg.sv
      - source/player_pkg.sv
      - source/frame_timer.sv
      - source/player_locator.sv
      - source/hand_action.sv
      - source/chop_board.sv
      - source/stove_pot.sv
      - source/kitchen_grid.sv
      - source/kitchen_top.sv
  - target: test
    files:
      - tb/kitchen_assert.sv
      - tb/kitchen_tb.sv

// ==== filelist.f ====
+incdir+include
source/kitchen_pkg.sv
source/player_pkg.sv
source/frame_timer.sv
source/player_locator.sv
source/hand_action.sv
source/chop_board.sv
source/stove_pot.sv
source/kitchen_grid.sv
source/kitchen_top.sv
tb/kitchen_assert.sv
tb/kitchen_tb.sv

// ==== include/kitchen_cfg.svh ====
`ifndef KITCHEN_CFG_SVH
`define KITCHEN_CFG_SVH

// counter grid
`define GRID_ROWS 8
`define GRID_COLS 13
`define ROW_W 3
`define COL_W 4

// pixel space
`define PIX_W 9
`define CELL_PX 32
`define SPRITE_HALF 16

// timer lengths in frames
`define CHOP_TIME 3
`define COOK_TIME 10
`define FIRE_TIME 5
`define TIME_W 4

// stations, as (row, col)
`define BOARD_ROW 7
`define BOARD_COL 2
`define STOVE_ROW 0
`define STOVE_COL 8
`define ONION_ROW_A 2
`define ONION_ROW_B 3
`define ONION_COL 0
`define BOWL_ROW 6
`define BOWL_COL 12
`define EXT_ROW 6
`define EXT_COL 0

`endif

// ==== source/chop_board.sv ====
`default_nettype none

`include "kitchen_cfg.svh"

module chop_board import kitchen_pkg::*, player_pkg::*; (
    input  wire logic           vsync,
    input  wire logic           reset,
    input  wire game_state_t    game_state,
    input  wire player_view_t   view1,
    input  wire player_view_t   view2,
    input  wire object_grid_t   object_grid,
    output logic [`TIME_W-1:0]  board_time,
    output grid_write_t         write
);

    logic go, restart, play, onion_on, any_start, any_over, done;

    // chopping just began, facing the board
    function automatic logic starts_chop(player_view_t v);
        return (v.state == P_CHOPPING) && (v.prev == P_NOTHING)
            && (v.front_row == `BOARD_ROW) && (v.front_col == `BOARD_COL);
    endfunction

    function automatic logic over_board(player_view_t v);
        return (v.state == P_CHOPPING) && (v.dir == DOWN)
            && (v.row == `BOARD_ROW - 1) && (v.col == `BOARD_COL);
    endfunction

    frame_timer #(.GIVEN_TIME(`CHOP_TIME)) chop_timer (
        .vsync(vsync), .reset(reset), .go(go), .restart(restart), .time_left(board_time)
    );

    assign play      = (game_state == PLAY);
    assign onion_on  = (object_grid[`BOARD_ROW][`BOARD_COL] == G_ONION_WHOLE);
    assign any_start = starts_chop(view1) || starts_chop(view2);
    assign any_over  = over_board(view1) || over_board(view2);
    assign done      = play && onion_on && (board_time == '0);

    assign write = '{valid: done, row: `ROW_W'(`BOARD_ROW), col: `COL_W'(`BOARD_COL),
                     obj: G_ONION_CHOPPED};

    always_ff @(posedge vsync) begin
        if (reset || (game_state == WELCOME)) begin
            go      <= 1'b0;
            restart <= 1'b1;
        end else if (!play) begin
            go <= 1'b0;   // hold progress
        end else if (done || any_start) begin
            go      <= 1'b0;
            restart <= 1'b1;
        end else if (any_over && onion_on) begin
            go      <= 1'b1;
            restart <= 1'b0;
        end else begin
            go <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/frame_timer.sv ====
`default_nettype none

`include "kitchen_cfg.svh"

module frame_timer #(
    parameter int GIVEN_TIME = `CHOP_TIME
) (
    input  wire logic                 vsync,
    input  wire logic                 reset,
    input  wire logic                 go,
    input  wire logic                 restart,
    output logic [`TIME_W-1:0]        time_left
);

    always_ff @(posedge vsync) begin
        if (reset || restart) begin
            time_left <= `TIME_W'(GIVEN_TIME);
        end else if (go && (time_left != '0)) begin
            time_left <= time_left - 1'b1;   // sticks at zero
        end
    end

endmodule

`default_nettype wire

// ==== source/hand_action.sv ====
`default_nettype none

`include "kitchen_cfg.svh"

module hand_action import kitchen_pkg::*, player_pkg::*; (
    input  wire player_view_t   view,
    input  wire object_grid_t   object_grid,
    input  wire game_state_t    game_state,
    output grid_write_t         write
);

    grid_object_t   front;
    logic           put_down, pick_up, at_supply;

    assign front = object_grid[view.front_row][view.front_col];

    assign put_down = (view.state == P_NOTHING) && (view.prev != P_NOTHING);
    assign pick_up  = (view.prev == P_NOTHING) && (view.state != P_NOTHING)
                   && (view.state != P_CHOPPING) && (view.state != P_EXT_ON);

    // onion and bowl supplies never run out
    assign at_supply =
        ((view.state == P_ONION_WHOLE) && (view.front_col == `ONION_COL)
         && ((view.front_row == `ONION_ROW_A) || (view.front_row == `ONION_ROW_B)))
        || ((view.state == P_BOWL_EMPTY) && (view.front_row == `BOWL_ROW)
         && (view.front_col == `BOWL_COL));

    always_comb begin
        write.valid = 1'b0;
        write.row   = view.front_row;
        write.col   = view.front_col;
        write.obj   = G_EMPTY;
        if (game_state == PLAY) begin
            if (put_down) begin
                write.valid = 1'b1;
                case (view.prev)
                    P_ONION_WHOLE: write.obj = G_ONION_WHOLE;
                    P_ONION_CHOPPED: begin
                        if (front == G_POT_EMPTY) begin
                            write.obj = G_POT_RAW;   // onion into pot
                        end else if (front == G_EMPTY) begin
                            write.obj = G_ONION_CHOPPED;
                        end else begin
                            write.valid = 1'b0;
                        end
                    end
                    P_POT_EMPTY: begin
                        if (front == G_ONION_CHOPPED) begin
                            write.obj = G_POT_RAW;
                        end else if (front == G_EMPTY) begin
                            write.obj = G_POT_EMPTY;
                        end else begin
                            write.valid = 1'b0;
                        end
                    end
                    P_POT_RAW:    write.obj = G_POT_RAW;
                    P_POT_COOKED: write.obj = G_POT_COOKED;
                    P_BOWL_EMPTY: write.obj = G_BOWL_EMPTY;
                    P_BOWL_FULL:  write.obj = G_BOWL_FULL;
                    P_EXT_OFF:    write.obj = G_EXTINGUISHER;
                    default:      write.valid = 1'b0;   // chopping or spraying
                endcase
            end else if (pick_up) begin
                write.valid = !at_supply;
            end else if ((view.state == P_EXT_ON) && (front == G_FIRE)) begin
                write.valid = 1'b1;
                write.obj   = G_POT_EMPTY;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/kitchen_grid.sv ====
`default_nettype none

`include "kitchen_cfg.svh"

module kitchen_grid import kitchen_pkg::*; (
    input  wire logic           vsync,
    input  wire logic           reset,
    input  wire game_state_t    game_state,
    input  wire grid_write_t    wr_p1,
    input  wire grid_write_t    wr_p2,
    input  wire grid_write_t    wr_board,
    input  wire grid_write_t    wr_stove,
    output object_grid_t        object_grid
);

    grid_write_t writes [4];

    function automatic object_grid_t start_layout();
        object_grid_t l;
        for (int r = 0; r < `GRID_ROWS; r++) begin
            for (int c = 0; c < `GRID_COLS; c++) begin
                l[r][c] = G_EMPTY;
            end
        end
        l[`ONION_ROW_A][`ONION_COL] = G_ONION_WHOLE;
        l[`ONION_ROW_B][`ONION_COL] = G_ONION_WHOLE;
        l[`BOWL_ROW][`BOWL_COL]     = G_BOWL_EMPTY;
        l[`STOVE_ROW][`STOVE_COL]   = G_POT_EMPTY;
        l[`EXT_ROW][`EXT_COL]       = G_EXTINGUISHER;
        return l;
    endfunction

    // lowest priority first, later writes overwrite
    assign writes = '{wr_p1, wr_p2, wr_board, wr_stove};

    always_ff @(posedge vsync) begin
        if (reset || (game_state == WELCOME)) begin
            object_grid <= start_layout();
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (writes[i].valid) begin
                    object_grid[writes[i].row][writes[i].col] <= writes[i].obj;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/kitchen_pkg.sv ====
`default_nettype none

`include "kitchen_cfg.svh"

package kitchen_pkg;

    // what can sit on a counter cell
    typedef enum logic [3:0] {
        G_EMPTY,
        G_ONION_WHOLE,
        G_ONION_CHOPPED,
        G_BOWL_EMPTY,
        G_BOWL_FULL,
        G_POT_EMPTY,
        G_POT_RAW,
        G_POT_COOKED,
        G_POT_FIRE,
        G_FIRE,
        G_EXTINGUISHER
    } grid_object_t;

    typedef enum logic [2:0] {WELCOME, START, PLAY, PAUSE, FINISH} game_state_t;

    typedef enum logic [1:0] {S_NONE, S_RAW, S_COOKED, S_BURNING} stove_state_t;

    // one cell update, applied at the next frame
    typedef struct packed {
        logic                valid;
        logic [`ROW_W-1:0]   row;
        logic [`COL_W-1:0]   col;
        grid_object_t        obj;
    } grid_write_t;

    typedef grid_object_t [`GRID_ROWS-1:0][`GRID_COLS-1:0] object_grid_t;

endpackage

`default_nettype wire

// ==== source/kitchen_top.sv ====
`default_nettype none

`include "kitchen_cfg.svh"

module kitchen_top import kitchen_pkg::*, player_pkg::*; (
    input  wire logic           vsync,
    input  wire logic           reset,
    input  wire game_state_t    game_state,
    input  wire player_in_t     player1,
    input  wire player_in_t     player2,
    output object_grid_t        object_grid,
    output logic [`TIME_W-1:0]  board_time,
    output logic [`TIME_W-1:0]  cook_time
);

    player_view_t   view1, view2;
    grid_write_t    wr_p1, wr_p2, wr_board, wr_stove;

    player_locator loc1 (.vsync(vsync), .reset(reset), .player(player1), .view(view1));
    player_locator loc2 (.vsync(vsync), .reset(reset), .player(player2), .view(view2));

    hand_action hand1 (
        .view(view1), .object_grid(object_grid), .game_state(game_state), .write(wr_p1)
    );
    hand_action hand2 (
        .view(view2), .object_grid(object_grid), .game_state(game_state), .write(wr_p2)
    );

    chop_board board (
        .vsync(vsync), .reset(reset), .game_state(game_state),
        .view1(view1), .view2(view2), .object_grid(object_grid),
        .board_time(board_time), .write(wr_board)
    );

    stove_pot stove (
        .vsync(vsync), .reset(reset), .game_state(game_state),
        .stove_cell(object_grid[`STOVE_ROW][`STOVE_COL]),
        .cook_time(cook_time), .write(wr_stove)
    );

    kitchen_grid grid (
        .vsync(vsync), .reset(reset), .game_state(game_state),
        .wr_p1(wr_p1), .wr_p2(wr_p2), .wr_board(wr_board), .wr_stove(wr_stove),
        .object_grid(object_grid)
    );

endmodule

`default_nettype wire

// ==== source/player_locator.sv ====
`default_nettype none

`include "kitchen_cfg.svh"

module player_locator import player_pkg::*; (
    input  wire logic         vsync,
    input  wire logic         reset,
    input  wire player_in_t   player,
    output player_view_t      view
);

    player_in_t          p_q;
    player_state_t       prev_q;
    logic [`PIX_W:0]     cx, cy;
    logic [`PIX_W:0]     col_full, row_full;
    logic [`COL_W-1:0]   col;
    logic [`ROW_W-1:0]   row;

    always_ff @(posedge vsync) begin
        p_q    <= player;
        prev_q <= p_q.state;
        if (reset) begin
            p_q.state <= P_NOTHING;
            prev_q    <= P_NOTHING;
        end
    end

    // sprite centre to cell index
    assign cx       = {1'b0, p_q.x} + (`PIX_W+1)'(`SPRITE_HALF);
    assign cy       = {1'b0, p_q.y} + (`PIX_W+1)'(`SPRITE_HALF);
    assign col_full = cx / (`PIX_W+1)'(`CELL_PX);
    assign row_full = cy / (`PIX_W+1)'(`CELL_PX);
    assign col = (col_full > `GRID_COLS - 1) ? `COL_W'(`GRID_COLS - 1) : col_full[`COL_W-1:0];
    assign row = (row_full > `GRID_ROWS - 1) ? `ROW_W'(`GRID_ROWS - 1) : row_full[`ROW_W-1:0];

    always_comb begin
        view.row       = row;
        view.col       = col;
        view.front_row = row;
        view.front_col = col;
        view.dir       = p_q.dir;
        view.state     = p_q.state;
        view.prev      = prev_q;
        case (p_q.dir)   // neighbour, held at the edge
            LEFT:  if (col != '0) view.front_col = col - 1'b1;
            RIGHT: if (col != `COL_W'(`GRID_COLS - 1)) view.front_col = col + 1'b1;
            UP:    if (row != '0) view.front_row = row - 1'b1;
            DOWN:  if (row != `ROW_W'(`GRID_ROWS - 1)) view.front_row = row + 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/player_pkg.sv ====
`default_nettype none

`include "kitchen_cfg.svh"

package player_pkg;

    // what the player is holding or doing
    typedef enum logic [3:0] {
        P_NOTHING,
        P_CHOPPING,
        P_ONION_WHOLE,
        P_ONION_CHOPPED,
        P_POT_EMPTY,
        P_POT_RAW,
        P_POT_COOKED,
        P_BOWL_EMPTY,
        P_BOWL_FULL,
        P_EXT_OFF,
        P_EXT_ON
    } player_state_t;

    typedef enum logic [1:0] {LEFT, RIGHT, UP, DOWN} direction_t;

    // raw input from the movement logic, sprite corner in pixels
    typedef struct packed {
        direction_t          dir;
        logic [`PIX_W-1:0]   x;
        logic [`PIX_W-1:0]   y;
        player_state_t       state;
    } player_in_t;

    typedef struct packed {
        logic [`ROW_W-1:0]   row;
        logic [`COL_W-1:0]   col;
        logic [`ROW_W-1:0]   front_row;
        logic [`COL_W-1:0]   front_col;
        direction_t          dir;
        player_state_t       state;
        player_state_t       prev;   // state one frame earlier
    } player_view_t;

endpackage

`default_nettype wire

// ==== source/stove_pot.sv ====
`default_nettype none

`include "kitchen_cfg.svh"

module stove_pot import kitchen_pkg::*; (
    input  wire logic           vsync,
    input  wire logic           reset,
    input  wire game_state_t    game_state,
    input  wire grid_object_t   stove_cell,
    output logic [`TIME_W-1:0]  cook_time,
    output grid_write_t         write
);

    stove_state_t          state;
    logic                  cook_go, cook_restart, fire_go, fire_restart;
    logic                  play, pot_live, cook_done, fire_done;
    logic [`TIME_W-1:0]    fire_left;

    frame_timer #(.GIVEN_TIME(`COOK_TIME)) cook_timer (
        .vsync(vsync), .reset(reset), .go(cook_go), .restart(cook_restart),
        .time_left(cook_time)
    );

    // time a cooked pot survives on the heat
    frame_timer #(.GIVEN_TIME(`FIRE_TIME)) fire_timer (
        .vsync(vsync), .reset(reset), .go(fire_go), .restart(fire_restart),
        .time_left(fire_left)
    );

    assign play      = (game_state == PLAY);
    assign pot_live  = (stove_cell != G_EMPTY) && (stove_cell != G_POT_EMPTY);
    assign cook_done = play && pot_live && (state == S_RAW) && (cook_time == '0);
    assign fire_done = play && pot_live && (state == S_COOKED) && (fire_left == '0);

    assign write = '{valid: cook_done || fire_done, row: `ROW_W'(`STOVE_ROW),
                     col: `COL_W'(`STOVE_COL), obj: fire_done ? G_FIRE : G_POT_COOKED};

    always_ff @(posedge vsync) begin
        if (reset || (game_state == WELCOME) || (play && !pot_live)) begin
            state        <= S_NONE;
            cook_go      <= 1'b0;
            cook_restart <= 1'b1;
            fire_go      <= 1'b0;
            fire_restart <= 1'b1;
        end else if (!play) begin
            cook_go <= 1'b0;
            fire_go <= 1'b0;
        end else begin
            case (state)
                S_NONE: if (stove_cell == G_POT_RAW) state <= S_RAW;
                S_RAW: begin
                    if (cook_done) begin
                        state        <= S_COOKED;
                        cook_go      <= 1'b0;
                        fire_restart <= 1'b1;
                    end else begin
                        cook_go      <= 1'b1;
                        cook_restart <= 1'b0;
                    end
                end
                S_COOKED: begin
                    if (fire_done) begin
                        state        <= S_BURNING;
                        fire_go      <= 1'b0;
                        fire_restart <= 1'b1;
                        cook_restart <= 1'b1;
                    end else begin
                        fire_go      <= 1'b1;
                        fire_restart <= 1'b0;
                    end
                end
                default: if (stove_cell != G_FIRE) state <= S_NONE;   // put out
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== tb/kitchen_assert.sv ====
`default_nettype none

`include "kitchen_cfg.svh"

module kitchen_assert import kitchen_pkg::*; (
    input  wire logic           vsync,
    input  wire logic           reset,
    input  wire game_state_t    game_state,
    input  wire object_grid_t   object_grid
);

    int             fails = 0;   // read by the testbench
    grid_object_t   stove_cell;

    function automatic object_grid_t start_grid();
        object_grid_t g;
        for (int r = 0; r < `GRID_ROWS; r++) begin
            for (int c = 0; c < `GRID_COLS; c++) begin
                g[r][c] = G_EMPTY;
            end
        end
        g[`ONION_ROW_A][`ONION_COL] = G_ONION_WHOLE;
        g[`ONION_ROW_B][`ONION_COL] = G_ONION_WHOLE;
        g[`BOWL_ROW][`BOWL_COL]     = G_BOWL_EMPTY;
        g[`STOVE_ROW][`STOVE_COL]   = G_POT_EMPTY;
        g[`EXT_ROW][`EXT_COL]       = G_EXTINGUISHER;
        return g;
    endfunction

    assign stove_cell = object_grid[`STOVE_ROW][`STOVE_COL];

    // first frame out of reset
    layout_after_reset: assert property (@(posedge vsync)
        $fell(reset) |-> (object_grid == start_grid()))
    else begin
        fails++;
        $error("grid differs from the start layout after reset");
    end

    layout_on_welcome: assert property (@(posedge vsync) disable iff (reset)
        (game_state == WELCOME) |=> (object_grid == start_grid()))
    else begin
        fails++;
        $error("welcome did not restore the start layout");
    end

    frozen_outside_play: assert property (@(posedge vsync) disable iff (reset)
        ((game_state != PLAY) && (game_state != WELCOME)) |=> $stable(object_grid))
    else begin
        fails++;
        $error("grid changed while the game was not in play");
    end

    // fire only grows out of a cooked pot
    fire_from_cooked: assert property (@(posedge vsync) disable iff (reset)
        ((stove_cell == G_FIRE) && ($past(stove_cell) != G_FIRE))
            |-> ($past(stove_cell) == G_POT_COOKED))
    else begin
        fails++;
        $error("fire on the stove without a cooked pot before it");
    end

endmodule

`default_nettype wire

// ==== tb/kitchen_tb.sv ====
`default_nettype none

`include "kitchen_cfg.svh"

module kitchen_tb import kitchen_pkg::*, player_pkg::*; ();

    logic                 vsync = 1'b0;
    logic                 reset;
    game_state_t          game_state;
    player_in_t           player1, player2;
    object_grid_t         object_grid;
    logic [`TIME_W-1:0]   board_time, cook_time;
    object_grid_t         snapshot;
    int                   seed = 35;
    int                   errors = 0;
    int                   timeouts = 0;

    kitchen_top uut (
        .vsync(vsync), .reset(reset), .game_state(game_state),
        .player1(player1), .player2(player2), .object_grid(object_grid),
        .board_time(board_time), .cook_time(cook_time)
    );

    bind kitchen_top kitchen_assert chk (
        .vsync(vsync), .reset(reset), .game_state(game_state), .object_grid(object_grid)
    );

    always #4 vsync = ~vsync;   // one frame every 8

    function automatic object_grid_t expected_layout();
        object_grid_t g;
        for (int r = 0; r < `GRID_ROWS; r++) begin
            for (int c = 0; c < `GRID_COLS; c++) begin
                g[r][c] = G_EMPTY;
            end
        end
        g[`ONION_ROW_A][`ONION_COL] = G_ONION_WHOLE;
        g[`ONION_ROW_B][`ONION_COL] = G_ONION_WHOLE;
        g[`BOWL_ROW][`BOWL_COL]     = G_BOWL_EMPTY;
        g[`STOVE_ROW][`STOVE_COL]   = G_POT_EMPTY;
        g[`EXT_ROW][`EXT_COL]       = G_EXTINGUISHER;
        return g;
    endfunction

    // sprite corner exactly on a cell
    function automatic player_in_t place(input int row, input int col, input direction_t dir,
                                         input player_state_t state);
        player_in_t p;
        p.dir   = dir;
        p.x     = `PIX_W'(col * `CELL_PX);
        p.y     = `PIX_W'(row * `CELL_PX);
        p.state = state;
        return p;
    endfunction

    function automatic player_in_t idle_spot();
        player_in_t p;
        p.dir   = direction_t'($unsigned($random(seed)) % 4);
        p.x     = `PIX_W'($unsigned($random(seed)) % ((`GRID_COLS - 1) * `CELL_PX + 1));
        p.y     = `PIX_W'($unsigned($random(seed)) % ((`GRID_ROWS - 1) * `CELL_PX + 1));
        p.state = P_NOTHING;
        return p;
    endfunction

    task automatic next_frames(input int n);
        repeat (n) @(posedge vsync);
        #1;
    endtask

    task automatic check_cell(input int r, input int c, input grid_object_t exp,
                              input string what);
        assert (object_grid[r][c] == exp) else begin
            errors++;
            $display("FAILED at time %0t: %s, cell (%0d,%0d) holds %0d, expected %0d",
                     $time, what, r, c, object_grid[r][c], exp);
        end
    endtask

    task automatic check_layout(input string what);
        assert (object_grid == expected_layout()) else begin
            errors++;
            $display("FAILED at time %0t: %s does not match the start layout", $time, what);
        end
    endtask

    task automatic wait_cell(input int r, input int c, input grid_object_t exp,
                             input int max_frames, input string what);
        int n;
        n = 0;
        while ((object_grid[r][c] != exp) && (n < max_frames)) begin
            @(posedge vsync);
            #1;
            n++;
        end
        if (object_grid[r][c] != exp) begin
            timeouts++;
            $display("timeout: %s did not happen within %0d frames", what, max_frames);
        end
    endtask

    initial begin
        reset      = 1'b1;
        game_state = WELCOME;
        player1    = idle_spot();
        player2    = idle_spot();
        repeat (3) @(posedge vsync);
        #1;
        reset = 1'b0;
        check_layout("grid after reset");
        assert ((board_time == `TIME_W'(`CHOP_TIME)) && (cook_time == `TIME_W'(`COOK_TIME)))
        else begin
            errors++;
            $display("FAILED at time %0t: timers not full after reset", $time);
        end
        game_state = PLAY;

        // onion supply never runs out
        player1 = place(`ONION_ROW_A, 1, LEFT, P_NOTHING);
        next_frames(1);
        player1.state = P_ONION_WHOLE;
        next_frames(2);
        check_cell(`ONION_ROW_A, `ONION_COL, G_ONION_WHOLE, "onion supply after pick-up");
        player1 = place(4, 4, RIGHT, P_ONION_WHOLE);
        next_frames(1);
        player1.state = P_NOTHING;
        next_frames(1);
        check_cell(4, 5, G_EMPTY, "cell one frame after put-down");
        next_frames(1);
        check_cell(4, 5, G_ONION_WHOLE, "onion put down two frames after release");

        // chop an onion on the board
        player1 = place(`ONION_ROW_B, 1, LEFT, P_NOTHING);
        next_frames(1);
        player1.state = P_ONION_WHOLE;
        next_frames(1);
        player1 = place(`BOARD_ROW - 1, `BOARD_COL, DOWN, P_ONION_WHOLE);
        next_frames(1);
        player1.state = P_NOTHING;
        wait_cell(`BOARD_ROW, `BOARD_COL, G_ONION_WHOLE, 4, "whole onion on the board");
        player1.state = P_CHOPPING;
        wait_cell(`BOARD_ROW, `BOARD_COL, G_ONION_CHOPPED, `CHOP_TIME + 4, "chopping");
        player1.state = P_NOTHING;
        next_frames(1);
        player1.state = P_ONION_CHOPPED;
        wait_cell(`BOARD_ROW, `BOARD_COL, G_EMPTY, 4, "chopped onion taken off the board");

        // onion into the pot, then cook and burn
        player1 = place(`STOVE_ROW + 1, `STOVE_COL, UP, P_ONION_CHOPPED);
        next_frames(1);
        player1.state = P_NOTHING;
        wait_cell(`STOVE_ROW, `STOVE_COL, G_POT_RAW, 4, "raw pot on the stove");
        wait_cell(`STOVE_ROW, `STOVE_COL, G_POT_COOKED, `COOK_TIME + 8, "cooking");
        wait_cell(`STOVE_ROW, `STOVE_COL, G_FIRE, `FIRE_TIME + 8, "pot catching fire");

        // second player puts the fire out
        player2 = place(`EXT_ROW, `EXT_COL + 1, LEFT, P_NOTHING);
        next_frames(1);
        player2.state = P_EXT_OFF;
        wait_cell(`EXT_ROW, `EXT_COL, G_EMPTY, 4, "extinguisher picked up");
        player2 = place(`STOVE_ROW + 1, `STOVE_COL, UP, P_EXT_OFF);
        next_frames(1);
        player2.state = P_EXT_ON;
        wait_cell(`STOVE_ROW, `STOVE_COL, G_POT_EMPTY, 4, "fire put out");
        player2.state = P_EXT_OFF;
        next_frames(2);

        // paused game ignores the players
        game_state = PAUSE;
        next_frames(1);
        snapshot = object_grid;
        player1.state = P_POT_EMPTY;
        player2.state = P_NOTHING;
        next_frames(3);
        assert (object_grid == snapshot) else begin
            errors++;
            $display("FAILED at time %0t: grid changed during pause", $time);
        end
        game_state = WELCOME;
        next_frames(2);
        check_layout("grid after welcome");
        next_frames(2);

        $display("errors: %0d value checks, %0d timeouts, %0d assertion failures",
                 errors, timeouts, uut.chk.fails);
        if ((errors == 0) && (timeouts == 0) && (uut.chk.fails == 0)) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
